// ==== build.f ====
design/chimePkg.sv
design/commandCapture.sv
design/noteDecoder.sv
design/chimeSequencer.sv
design/doorbellChime.sv
dv/doorbellChime_properties.sv
dv/doorbellChimeTb.sv

// ==== design/chimePkg.sv ====
package chimePkg;

	////////////////////
	// command word layout
	////////////////////

	// bits shifted in per command
	localparam int wordWidth = 40;

	// notes played per pass
	localparam int noteCount = 4;
	localparam int noteIdxWidth = $clog2(noteCount);
	localparam logic [noteIdxWidth-1:0] lastNoteIdx = noteIdxWidth'(noteCount - 1);

	// tone code and duration code are the same width
	localparam int codeWidth = 4;
	localparam int toneCount = 2 ** codeWidth;

	// one note field holds tone code then duration code
	localparam int noteFieldWidth = 2 * codeWidth;
	// note 0 sits in the top bits of the word
	localparam int firstNoteLsb = wordWidth - noteFieldWidth;

	// repeat byte closes the word, low bits only
	localparam int repeatLsb = 0;
	localparam int repeatWidth = 2;

	////////////////////
	// count tables
	////////////////////

	// half-period and note-length counters
	localparam int countWidth = 32;

	// half period of each tone in 24 MHz cycles
	localparam logic [countWidth-1:0] toneHalfPeriod [toneCount] = '{
		// a3 and b3
		32'd54544,
		32'd48582,
		// c4 up to b4
		32'd45801,
		32'd40815,
		32'd36363,
		32'd34383,
		32'd30611,
		32'd27272,
		32'd24290,
		// c5 up to a5
		32'd22944,
		32'd20442,
		32'd18208,
		32'd17191,
		32'd15305,
		32'd13635,
		// spare code plays a4 again
		32'd27272
	};

	// note lengths at 24 MHz, one second per whole note
	localparam logic [countWidth-1:0] wholeNote = 32'd24000000;
	localparam logic [countWidth-1:0] halfNote = 32'd12000000;
	localparam logic [countWidth-1:0] quarterNote = 32'd6000000;

	// duration codes split into three bands
	localparam logic [codeWidth-1:0] halfNoteFirst = 4'd5;
	localparam logic [codeWidth-1:0] quarterNoteFirst = 4'd11;

	////////////////////
	// sequencer states
	////////////////////
	typedef enum logic [1:0] {
		idle,
		playNote,
		nextNote,
		complete
	} seqState;

endpackage

// ==== design/chimeSequencer.sv ====
module chimeSequencer (
	input  logic int_osc,
	input  logic reset,
	input  logic start,
	input  logic [chimePkg::noteCount*chimePkg::countWidth-1:0] halfPeriod,
	input  logic [chimePkg::noteCount*chimePkg::countWidth-1:0] noteLength,
	input  logic [chimePkg::repeatWidth-1:0] repeatCount,
	output logic makingMusic,
	output logic pwm
);

	chimePkg::seqState state;
	chimePkg::seqState stateNext;

	// note and pass tracking
	logic [chimePkg::noteIdxWidth-1:0] noteIdx;
	logic [chimePkg::noteIdxWidth-1:0] loadIdx;
	logic [chimePkg::repeatWidth-1:0] passCnt;
	logic lastNote;
	logic lastPass;

	// note length down-counter
	logic [chimePkg::countWidth-1:0] lenCnt;
	logic [chimePkg::countWidth-1:0] loadLen;

	// square wave counter
	logic [chimePkg::countWidth-1:0] toneCnt;
	logic [chimePkg::countWidth-1:0] curHalf;

	logic noteLoad;
	logic playingNext;

	////////////////////
	// note select
	////////////////////

	assign lastNote = (noteIdx == chimePkg::lastNoteIdx);
	// passCnt counts finished passes
	assign lastPass = (passCnt == repeatCount);

	// a note begins on start or after the closing cycle of the one before
	assign noteLoad = ((state == chimePkg::idle) && start) ||
		((state == chimePkg::nextNote) && !(lastNote && lastPass));

	// wraps to note 0 for the next pass
	assign loadIdx = ((state == chimePkg::nextNote) && !lastNote) ? noteIdx + 1'b1 : '0;
	assign loadLen = noteLength[loadIdx*chimePkg::countWidth +: chimePkg::countWidth];
	assign curHalf = halfPeriod[noteIdx*chimePkg::countWidth +: chimePkg::countWidth];

	////////////////////
	// state machine
	////////////////////

	// playNote holds noteLength cycles, nextNote adds the last one
	always_comb begin
		stateNext = state;
		case (state)
			chimePkg::idle: begin
				if (start && (loadLen == '0)) begin
					// zero length note lives only in nextNote
					stateNext = chimePkg::nextNote;
				end else if (start) begin
					stateNext = chimePkg::playNote;
				end
			end
			chimePkg::playNote: begin
				if (lenCnt == 1) begin
					stateNext = chimePkg::nextNote;
				end
			end
			chimePkg::nextNote: begin
				if (lastNote && lastPass) begin
					stateNext = chimePkg::complete;
				end else if (loadLen == '0) begin
					stateNext = chimePkg::nextNote;
				end else begin
					stateNext = chimePkg::playNote;
				end
			end
			chimePkg::complete: begin
				// one quiet cycle before idle
				stateNext = chimePkg::idle;
			end
		endcase
	end

	always_ff @(posedge int_osc) begin
		if (reset) begin
			state <= chimePkg::idle;
			noteIdx <= '0;
			passCnt <= '0;
			lenCnt <= '0;
		end else begin
			state <= stateNext;
			if (noteLoad) begin
				noteIdx <= loadIdx;
				lenCnt <= loadLen;
			end else if (state == chimePkg::playNote) begin
				lenCnt <= lenCnt - 1'b1;
			end
			// pass ends when note 3 hands back to note 0
			if (state == chimePkg::idle) begin
				passCnt <= '0;
			end else if ((state == chimePkg::nextNote) && noteLoad && lastNote) begin
				passCnt <= passCnt + 1'b1;
			end
		end
	end

	assign makingMusic = (state == chimePkg::playNote) || (state == chimePkg::nextNote);

	////////////////////
	// square wave
	////////////////////

	assign playingNext = (stateNext == chimePkg::playNote) ||
		(stateNext == chimePkg::nextNote);

	// every note starts low with a fresh count
	always_ff @(posedge int_osc) begin
		if (reset) begin
			toneCnt <= '0;
			pwm <= 1'b0;
		end else if (noteLoad || !playingNext) begin
			toneCnt <= '0;
			pwm <= 1'b0;
		end else if (toneCnt == curHalf) begin
			// toggle every halfPeriod + 1 cycles
			toneCnt <= '0;
			pwm <= ~pwm;
		end else begin
			toneCnt <= toneCnt + 1'b1;
		end
	end

endmodule

// ==== design/commandCapture.sv ====
module commandCapture (
	input  logic int_osc,
	input  logic reset,
	input  logic sck,
	input  logic sdi,
	input  logic ce,
	input  logic makingMusic,
	output logic start,
	output logic [chimePkg::noteCount*chimePkg::codeWidth-1:0] toneCode,
	output logic [chimePkg::noteCount*chimePkg::codeWidth-1:0] durCode,
	output logic [chimePkg::repeatWidth-1:0] repeatCount
);

	// serial word, msb first
	logic [chimePkg::wordWidth-1:0] shiftReg;

	// ce synchronizer and edge pipe
	logic ceMeta;
	logic ceSync;
	logic ceLast;
	logic ceFall;

	// frame ended and the chime is free
	logic captureNow;

	////////////////////
	// sck domain
	////////////////////

	// sample sdi on the rising sck edge
	always_ff @(posedge sck) begin
		shiftReg <= {shiftReg[chimePkg::wordWidth-2:0], sdi};
	end

	////////////////////
	// int_osc domain
	////////////////////

	// a new frame while playing is simply dropped
	assign captureNow = ceFall && !makingMusic;

	always_ff @(posedge int_osc) begin
		if (reset) begin
			// ce idles high
			ceMeta <= 1'b1;
			ceSync <= 1'b1;
			ceLast <= 1'b1;
			ceFall <= 1'b0;
			start <= 1'b0;
		end else begin
			// two flops before ce is trusted
			ceMeta <= ce;
			ceSync <= ceMeta;
			ceLast <= ceSync;
			// registered falling edge
			ceFall <= ceLast && !ceSync;
			// one cycle strobe
			start <= captureNow;
		end
	end

	// sck is quiet here, so shiftReg is stable
	always_ff @(posedge int_osc) begin
		if (captureNow) begin
			for (int i = 0; i < chimePkg::noteCount; i++) begin
				// tone code is the upper half of a note field
				toneCode[i*chimePkg::codeWidth +: chimePkg::codeWidth] <= shiftReg[
					chimePkg::firstNoteLsb - i*chimePkg::noteFieldWidth + chimePkg::codeWidth
					+: chimePkg::codeWidth];
				durCode[i*chimePkg::codeWidth +: chimePkg::codeWidth] <= shiftReg[
					chimePkg::firstNoteLsb - i*chimePkg::noteFieldWidth +: chimePkg::codeWidth];
			end
			// upper repeat bits are ignored
			repeatCount <= shiftReg[chimePkg::repeatLsb +: chimePkg::repeatWidth];
		end
	end

endmodule

// ==== design/doorbellChime.sv ====
module doorbellChime #(
	// 0 for the real 24 MHz time base
	parameter int timeScale = 0
) (
	input  logic int_osc,
	input  logic reset,
	input  logic sck,
	input  logic sdi,
	input  logic ce,
	output logic pwm,
	output logic makingMusic
);

	// latched command fields
	logic start;
	logic [chimePkg::noteCount*chimePkg::codeWidth-1:0] toneCode;
	logic [chimePkg::noteCount*chimePkg::codeWidth-1:0] durCode;
	logic [chimePkg::repeatWidth-1:0] repeatCount;

	// decoded counts, one slice per note
	logic [chimePkg::noteCount*chimePkg::countWidth-1:0] halfPeriod;
	logic [chimePkg::noteCount*chimePkg::countWidth-1:0] noteLength;

	////////////////////
	// serial capture
	////////////////////
	commandCapture captureInst (
		.int_osc(int_osc),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.ce(ce),
		.makingMusic(makingMusic),
		.start(start),
		.toneCode(toneCode),
		.durCode(durCode),
		.repeatCount(repeatCount)
	);

	////////////////////
	// note decoders
	////////////////////
	for (genvar i = 0; i < chimePkg::noteCount; i++) begin : genNote
		noteDecoder #(
			.timeScale(timeScale)
		) decoderInst (
			.toneCode(toneCode[i*chimePkg::codeWidth +: chimePkg::codeWidth]),
			.durCode(durCode[i*chimePkg::codeWidth +: chimePkg::codeWidth]),
			.halfPeriod(halfPeriod[i*chimePkg::countWidth +: chimePkg::countWidth]),
			.noteLength(noteLength[i*chimePkg::countWidth +: chimePkg::countWidth])
		);
	end

	////////////////////
	// playback
	////////////////////
	chimeSequencer sequencerInst (
		.int_osc(int_osc),
		.reset(reset),
		.start(start),
		.halfPeriod(halfPeriod),
		.noteLength(noteLength),
		.repeatCount(repeatCount),
		.makingMusic(makingMusic),
		.pwm(pwm)
	);

endmodule

// ==== design/noteDecoder.sv ====
module noteDecoder #(
	// right shift applied to every count
	parameter int timeScale = 0
) (
	input  logic [chimePkg::codeWidth-1:0] toneCode,
	input  logic [chimePkg::codeWidth-1:0] durCode,
	output logic [chimePkg::countWidth-1:0] halfPeriod,
	output logic [chimePkg::countWidth-1:0] noteLength
);

	// counts at the full 24 MHz time base
	logic [chimePkg::countWidth-1:0] halfRaw;
	logic [chimePkg::countWidth-1:0] lengthRaw;

	////////////////////
	// tone lookup
	////////////////////

	// one entry per code, all 16 codes are defined
	assign halfRaw = chimePkg::toneHalfPeriod[toneCode];

	////////////////////
	// duration bands
	////////////////////

	always_comb begin
		if (durCode < chimePkg::halfNoteFirst) begin
			// codes 0 to 4
			lengthRaw = chimePkg::wholeNote;
		end else if (durCode < chimePkg::quarterNoteFirst) begin
			// codes 5 to 10
			lengthRaw = chimePkg::halfNote;
		end else begin
			// codes 11 to 15
			lengthRaw = chimePkg::quarterNote;
		end
	end

	////////////////////
	// time base
	////////////////////

	// shorter time base for simulation
	assign halfPeriod = halfRaw >> timeScale;
	assign noteLength = lengthRaw >> timeScale;

endmodule

// ==== dv/doorbellChimeTb.sv ====
module doorbellChimeTb;

	// shortened time base, whole note is 23437 cycles
	localparam int timeScale = 10;
	localparam int period = 40;

	////////////////////
	// watchdog budget
	////////////////////

	// one pass, then 2 to 4 passes, then the ignored-command chime
	localparam int plannedPasses = 1 + (2 + 3 + 4) + 1;
	localparam int commandCount = 6;
	localparam int longestNote = int'(chimePkg::wholeNote >> timeScale) + 1;
	// framing, sync delay and idle gaps per command
	localparam int commandSlack = 2000;
	localparam longint watchdogTime = longint'(plannedPasses * chimePkg::noteCount * longestNote
		+ commandCount * commandSlack) * period;

	logic int_osc;
	logic reset;
	logic sck;
	logic sdi;
	logic ce;
	logic pwm;
	logic makingMusic;

	// codes of the command being built
	logic [chimePkg::codeWidth-1:0] tones [chimePkg::noteCount];
	logic [chimePkg::codeWidth-1:0] durs [chimePkg::noteCount];
	int errorCount = 0;

	doorbellChime #(
		.timeScale(timeScale)
	) i_dut (
		.int_osc(int_osc),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.ce(ce),
		.pwm(pwm),
		.makingMusic(makingMusic)
	);

	bind doorbellChime doorbellChimeProperties props (
		.int_osc(int_osc),
		.reset(reset),
		.ce(ce),
		.pwm(pwm),
		.makingMusic(makingMusic),
		.halfPeriod(halfPeriod),
		.noteIdx(sequencerInst.noteIdx)
	);

	initial begin
		int_osc = 1'b0;
		forever #(period / 2) int_osc = ~int_osc;
	end

	initial begin
		#(watchdogTime);
		$display("timeout: chime did not end within %0d time units", watchdogTime);
		$display("TB FAILED");
		$finish;
	end

	////////////////////
	// expected counts
	////////////////////

	function automatic int halfCount(input logic [chimePkg::codeWidth-1:0] tone);
		return int'(chimePkg::toneHalfPeriod[tone] >> timeScale);
	endfunction

	// codes 0-4 whole, 5-10 half, 11-15 quarter
	function automatic int lengthCount(input logic [chimePkg::codeWidth-1:0] dur);
		if (dur < chimePkg::halfNoteFirst) begin
			return int'(chimePkg::wholeNote >> timeScale);
		end else if (dur < chimePkg::quarterNoteFirst) begin
			return int'(chimePkg::halfNote >> timeScale);
		end
		return int'(chimePkg::quarterNote >> timeScale);
	endfunction

	// each note adds one closing cycle
	function automatic int chimeLength(input int passes);
		int sum;
		sum = 0;
		for (int n = 0; n < chimePkg::noteCount; n++) begin
			sum += lengthCount(durs[n]) + 1;
		end
		return sum * passes;
	endfunction

	// note 0 first, repeat byte last
	function automatic logic [chimePkg::wordWidth-1:0] commandWord(input logic [7:0] repByte);
		logic [chimePkg::wordWidth-1:0] word;
		word = '0;
		for (int n = 0; n < chimePkg::noteCount; n++) begin
			word = {word[chimePkg::wordWidth-chimePkg::noteFieldWidth-1:0], tones[n], durs[n]};
		end
		return {word[chimePkg::wordWidth-9:0], repByte};
	endfunction

	task automatic pickCodes();
		logic [31:0] rnd;
		for (int n = 0; n < chimePkg::noteCount; n++) begin
			rnd = $urandom();
			tones[n] = rnd[chimePkg::codeWidth-1:0];
			durs[n] = rnd[2*chimePkg::codeWidth-1:chimePkg::codeWidth];
		end
	endtask

	////////////////////
	// serial host
	////////////////////

	task automatic sendWord(input logic [chimePkg::wordWidth-1:0] word);
		for (int i = chimePkg::wordWidth - 1; i >= 0; i--) begin
			@(posedge int_osc);
			sdi <= word[i];
			sck <= 1'b0;
			@(posedge int_osc);
			sck <= 1'b1;
		end
		@(posedge int_osc);
		sck <= 1'b0;
		// sck stays still around the ce fall
		repeat (4) @(posedge int_osc);
		ce <= 1'b0;
		// ce back high before the chime can start
		repeat (2) @(posedge int_osc);
		ce <= 1'b1;
	endtask

	// length of the next chime, plus pwm spacing inside note 0
	task automatic measureChime(input int expLen, input int expHalf, input int firstLen);
		int len;
		int lastEdge;
		int toggles;
		logic pwmPrev;
		len = 0;
		lastEdge = 0;
		toggles = 0;
		pwmPrev = 1'b0;
		@(negedge int_osc);
		while (!makingMusic) @(negedge int_osc);
		while (makingMusic) begin
			if (len <= firstLen && pwm != pwmPrev) begin
				if (len - lastEdge != expHalf + 1) begin
					$display("[ERROR] %0t: pwm edge gap %0d, expected %0d", $time,
						len - lastEdge, expHalf + 1);
					errorCount++;
				end
				lastEdge = len;
				toggles++;
			end
			pwmPrev = pwm;
			len++;
			@(negedge int_osc);
		end
		if (len != expLen) begin
			$display("[ERROR] %0t: chime length %0d, expected %0d", $time, len, expLen);
			errorCount++;
		end
		if (toggles == 0) begin
			$display("[ERROR] %0t: pwm never toggled in note 0", $time);
			errorCount++;
		end
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		int expLen;
		int expHalf;
		int firstLen;
		logic [31:0] rnd;
		logic secondChime;
		void'($urandom(32'h04e7b461));
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		ce = 1'b1;
		repeat (2) @(posedge int_osc);
		reset <= 1'b0;
		repeat (4) @(posedge int_osc);

		// single pass
		pickCodes();
		sendWord(commandWord(8'h00));
		measureChime(chimeLength(1), halfCount(tones[0]), lengthCount(durs[0]));

		// 2 to 4 passes, junk in the unused repeat bits
		for (int rep = 1; rep <= 3; rep++) begin
			pickCodes();
			rnd = $urandom();
			sendWord(commandWord({rnd[5:0] | 6'd1, 2'(rep)}));
			measureChime(chimeLength(rep + 1), halfCount(tones[0]), lengthCount(durs[0]));
		end

		// second command framed mid chime
		pickCodes();
		expLen = chimeLength(1);
		expHalf = halfCount(tones[0]);
		firstLen = lengthCount(durs[0]);
		sendWord(commandWord(8'h00));
		fork
			measureChime(expLen, expHalf, firstLen);
			begin
				wait (makingMusic);
				repeat (200) @(posedge int_osc);
				pickCodes();
				sendWord(commandWord(8'h03));
			end
		join
		secondChime = 1'b0;
		repeat (200) begin
			@(negedge int_osc);
			if (makingMusic) begin
				secondChime = 1'b1;
			end
		end
		if (secondChime) begin
			$display("[ERROR] %0t: ignored command started a chime", $time);
			errorCount++;
		end

		$display("check errors: %0d, assertion failures: %0d", errorCount, i_dut.props.failCount);
		if (errorCount == 0 && i_dut.props.failCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/doorbellChime_properties.sv ====
module doorbellChimeProperties (
	input logic int_osc,
	input logic reset,
	input logic ce,
	input logic pwm,
	input logic makingMusic,
	input logic [chimePkg::noteCount*chimePkg::countWidth-1:0] halfPeriod,
	input logic [chimePkg::noteIdxWidth-1:0] noteIdx
);

	// failed assertions, summed up by the testbench
	int failCount = 0;

	// last cycle's view of the outputs
	logic pwmLast;
	logic musicLast;
	logic [chimePkg::noteIdxWidth-1:0] idxLast;

	// cycles since a note start or a pwm edge
	logic [chimePkg::countWidth-1:0] gap;
	logic [chimePkg::countWidth-1:0] curHalf;
	logic noteStart;
	logic toggled;

	assign curHalf = halfPeriod[noteIdx*chimePkg::countWidth +: chimePkg::countWidth];
	// every note moves the index, so a change marks a new note
	assign noteStart = (makingMusic && !musicLast) || (noteIdx != idxLast);
	assign toggled = (pwm != pwmLast);

	always_ff @(posedge int_osc) begin
		if (reset) begin
			pwmLast <= 1'b0;
			musicLast <= 1'b0;
			idxLast <= '0;
			gap <= '0;
		end else begin
			pwmLast <= pwm;
			musicLast <= makingMusic;
			idxLast <= noteIdx;
			if (noteStart || toggled) begin
				gap <= 32'd1;
			end else begin
				gap <= gap + 1'b1;
			end
		end
	end

	////////////////////
	// idle output
	////////////////////

	quietAfterReset: assert property (@(posedge int_osc) reset |=> (!makingMusic && !pwm))
		else begin
			$error("output high right after reset");
			failCount++;
		end

	pwmLowIdle: assert property (@(posedge int_osc) disable iff (reset) !makingMusic |-> !pwm)
		else begin
			$error("pwm high while no chime plays");
			failCount++;
		end

	// the falling edge at the end of a chime is allowed
	pwmStillIdle: assert property (@(posedge int_osc) disable iff (reset)
		(!makingMusic && !musicLast) |-> !toggled)
		else begin
			$error("pwm moved while idle");
			failCount++;
		end

	////////////////////
	// tone and framing
	////////////////////

	toggleGap: assert property (@(posedge int_osc) disable iff (reset)
		(makingMusic && toggled && !noteStart) |-> (gap == curHalf + 1'b1))
		else begin
			$error("pwm half period differs from decoded count");
			failCount++;
		end

	// two sync flops, edge flop, start flop, then the FSM
	startAfterCe: assert property (@(posedge int_osc) disable iff (reset)
		(makingMusic && !musicLast) |-> (!$past(ce, 5) && $past(ce, 6)))
		else begin
			$error("chime began without a ce fall");
			failCount++;
		end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the doorbell chime testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module doorbellChimeTb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

# keep running past assertion failures so the testbench can count them
output=$(./obj_dir/VdoorbellChimeTb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
